//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define IMEM_DEPTH       256
`define DMEM_DEPTH       256
`define MMIO_SWITCH_ADDR 32'hffff_fff0
`define MMIO_LED_ADDR    32'hffff_fff4
`define LED_WIDTH        8
`define RESET_PC         32'h0000_0000

`endif

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b      // lui passes the immediate through.
    } alu_op_e;

    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

endpackage

`default_nettype wire

//--- pipe_if.sv
`default_nettype none

interface ex_bus_if;
    import cpu_pkg::*;
    logic     valid;
    data_t    pc;
    alu_op_e  alu_op;
    data_t    rs1_data, rs2_data, imm;
    reg_idx_t rs1, rs2, rd;
    logic     use_imm, reg_write, mem_read, mem_write;
    logic     is_branch, branch_ne, is_jal;

    modport producer (
        output valid, pc, alu_op, rs1_data, rs2_data, imm, rs1, rs2, rd,
               use_imm, reg_write, mem_read, mem_write, is_branch, branch_ne, is_jal
    );
    modport consumer (
        input valid, pc, alu_op, rs1_data, rs2_data, imm, rs1, rs2, rd,
              use_imm, reg_write, mem_read, mem_write, is_branch, branch_ne, is_jal
    );
endinterface

interface mem_bus_if;
    import cpu_pkg::*;
    logic     valid;
    data_t    pc, alu_result, store_data;
    reg_idx_t rd;
    logic     reg_write, mem_read, mem_write;

    modport producer (output valid, pc, rd, alu_result, store_data, reg_write, mem_read, mem_write);
    modport consumer (input valid, pc, rd, alu_result, store_data, reg_write, mem_read, mem_write);
endinterface

`default_nettype wire

//--- imem_loader.sv
`default_nettype none
`include "cpu_params.svh"

module imem_loader (
    input  logic           cpuclk,
    input  logic           uart_done,
    input  cpu_pkg::data_t uart_addr,
    input  cpu_pkg::data_t uart_data,
    input  cpu_pkg::data_t fetch_pc,
    output cpu_pkg::data_t fetch_inst
);
    import cpu_pkg::*;

    localparam int aw = $clog2(`IMEM_DEPTH);

    data_t mem [`IMEM_DEPTH];

    // uart_addr is a word index.
    always_ff @(posedge cpuclk) begin
        if (!uart_done) begin
            mem[uart_addr[aw-1:0]] <= uart_data;
        end
    end

    assign fetch_inst = mem[fetch_pc[aw+1:2]]; // async read, byte pc.

    // loader must stay inside the array, upper bits are dropped otherwise.
    a_load_in_range: assert property (
        @(posedge cpuclk) !uart_done |-> (uart_addr < `IMEM_DEPTH)
    ) else $error("imem write beyond depth at word %0d", uart_addr);

endmodule

`default_nettype wire

//--- fetch_stage.sv
`default_nettype none
`include "cpu_params.svh"

module fetch_stage (
    input  logic           cpuclk,
    input  logic           rst_n,
    input  logic           redirect,
    input  cpu_pkg::data_t redirect_pc,
    output cpu_pkg::data_t fetch_pc,
    input  cpu_pkg::data_t fetch_inst,
    output logic           id_valid,
    output cpu_pkg::data_t id_pc,
    output cpu_pkg::data_t id_inst
);

    // predict not taken, redirect comes late from execute.
    always_ff @(posedge cpuclk) begin
        if (!rst_n) begin
            fetch_pc <= `RESET_PC;
        end else if (redirect) begin
            fetch_pc <= redirect_pc;
        end else begin
            fetch_pc <= fetch_pc + 32'd4;
        end
    end

    always_ff @(posedge cpuclk) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= !redirect; // wrong-path slot killed.
        end
    end

    always_ff @(posedge cpuclk) begin
        id_pc   <= fetch_pc;
        id_inst <= fetch_inst;
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic              cpuclk,
    input  logic              rst_n,
    input  logic              id_valid,
    input  cpu_pkg::data_t    id_pc,
    input  cpu_pkg::data_t    id_inst,
    input  logic              redirect,
    output cpu_pkg::reg_idx_t rs1,
    output cpu_pkg::reg_idx_t rs2,
    input  cpu_pkg::data_t    rs1_data,
    input  cpu_pkg::data_t    rs2_data,
    ex_bus_if.producer        ex
);
    import cpu_pkg::*;

    reg_idx_t rd;
    funct3_t  funct3;
    alu_op_e  d_alu_op;
    data_t    d_imm;
    logic     d_use_imm, d_reg_write, d_mem_read, d_mem_write;
    logic     d_is_branch, d_branch_ne, d_is_jal;

    assign rs1    = id_inst[19:15];
    assign rs2    = id_inst[24:20];
    assign rd     = id_inst[11:7];
    assign funct3 = id_inst[14:12];

    always_comb begin
        d_alu_op    = alu_add;
        d_imm       = '0;
        d_use_imm   = 1'b0;
        d_reg_write = 1'b0;
        d_mem_read  = 1'b0;
        d_mem_write = 1'b0;
        d_is_branch = 1'b0;
        d_branch_ne = 1'b0;
        d_is_jal    = 1'b0;
        case (id_inst[6:0])
            op_lui: begin
                d_alu_op    = alu_pass_b;
                d_use_imm   = 1'b1;
                d_reg_write = 1'b1;
                d_imm       = {id_inst[31:12], 12'b0};
            end
            op_imm: begin
                d_use_imm   = 1'b1;
                d_reg_write = (funct3 == 3'b000); // addi only.
                d_imm       = {{20{id_inst[31]}}, id_inst[31:20]};
            end
            op_reg: begin
                d_reg_write = 1'b1;
                case (funct3)
                    3'b000:  d_alu_op = id_inst[30] ? alu_sub : alu_add;
                    3'b010:  d_alu_op = alu_slt;
                    3'b100:  d_alu_op = alu_xor;
                    3'b110:  d_alu_op = alu_or;
                    3'b111:  d_alu_op = alu_and;
                    default: d_reg_write = 1'b0;
                endcase
            end
            op_load: begin
                d_use_imm   = 1'b1;
                d_mem_read  = (funct3 == 3'b010);
                d_reg_write = (funct3 == 3'b010);
                d_imm       = {{20{id_inst[31]}}, id_inst[31:20]};
            end
            op_store: begin
                d_use_imm   = 1'b1;
                d_mem_write = (funct3 == 3'b010);
                d_imm       = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
            end
            op_branch: begin
                d_is_branch = (funct3[2:1] == 2'b00); // beq, bne.
                d_branch_ne = funct3[0];
                d_imm = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                         id_inst[11:8], 1'b0};
            end
            op_jal: begin
                d_is_jal    = 1'b1;
                d_reg_write = 1'b1;
                d_imm = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                         id_inst[30:21], 1'b0};
            end
            default: ;
        endcase
        if (rd == '0) begin
            d_reg_write = 1'b0; // x0 writes dropped here.
        end
    end

    always_ff @(posedge cpuclk) begin
        if (!rst_n) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= id_valid && !redirect;
        end
    end

    always_ff @(posedge cpuclk) begin
        ex.pc        <= id_pc;
        ex.alu_op    <= d_alu_op;
        ex.rs1_data  <= rs1_data;
        ex.rs2_data  <= rs2_data;
        ex.imm       <= d_imm;
        ex.rs1       <= rs1;
        ex.rs2       <= rs2;
        ex.rd        <= rd;
        ex.use_imm   <= d_use_imm;
        ex.reg_write <= d_reg_write;
        ex.mem_read  <= d_mem_read;
        ex.mem_write <= d_mem_write;
        ex.is_branch <= d_is_branch;
        ex.branch_ne <= d_branch_ne;
        ex.is_jal    <= d_is_jal;
    end

endmodule

`default_nettype wire

//--- regfile.sv
`default_nettype none

module regfile (
    input  logic              cpuclk,
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    output cpu_pkg::data_t    rs1_data,
    output cpu_pkg::data_t    rs2_data,
    input  logic              wb_we,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  cpu_pkg::data_t    wb_data
);
    import cpu_pkg::*;

    data_t regs [1:31];

    function automatic data_t read_port(input reg_idx_t idx, input data_t stored,
                                        input logic we, input reg_idx_t rd, input data_t wd);
        if (idx == '0) begin
            return '0;
        end
        if (we && (rd == idx)) begin
            return wd; // same-cycle write seen by decode.
        end
        return stored;
    endfunction

    always_ff @(posedge cpuclk) begin
        if (wb_we && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_data = read_port(rs1, regs[rs1], wb_we, wb_rd, wb_data);
    assign rs2_data = read_port(rs2, regs[rs2], wb_we, wb_rd, wb_data);

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic              cpuclk,
    input  logic              rst_n,
    ex_bus_if.consumer        ex,
    input  logic              wb_we,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  cpu_pkg::data_t    wb_data,
    output logic              redirect,
    output cpu_pkg::data_t    redirect_pc,
    mem_bus_if.producer       mem
);
    import cpu_pkg::*;

    data_t op_a, op_b_reg, op_b, alu_out, result;
    logic  equal;

    // only the mem stage is ahead, older values are already in the regfile.
    function automatic data_t fwd(input reg_idx_t idx, input data_t reg_val,
                                  input logic we, input reg_idx_t rd, input data_t wd);
        if (we && (rd != '0) && (rd == idx)) begin
            return wd;
        end
        return reg_val;
    endfunction

    assign op_a     = fwd(ex.rs1, ex.rs1_data, wb_we, wb_rd, wb_data);
    assign op_b_reg = fwd(ex.rs2, ex.rs2_data, wb_we, wb_rd, wb_data);
    assign op_b     = ex.use_imm ? ex.imm : op_b_reg;

    always_comb begin
        case (ex.alu_op)
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_slt:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    assign result = ex.is_jal ? ex.pc + 32'd4 : alu_out; // link value.
    assign equal  = (op_a == op_b_reg);

    assign redirect    = ex.valid && (ex.is_jal || (ex.is_branch && (equal != ex.branch_ne)));
    assign redirect_pc = ex.pc + ex.imm;

    always_ff @(posedge cpuclk) begin
        if (!rst_n) begin
            mem.valid <= 1'b0;
        end else begin
            mem.valid <= ex.valid;
        end
    end

    always_ff @(posedge cpuclk) begin
        mem.pc         <= ex.pc;
        mem.rd         <= ex.rd;
        mem.alu_result <= result;
        mem.store_data <= op_b_reg; // forwarded rs2 for sw.
        mem.reg_write  <= ex.reg_write;
        mem.mem_read   <= ex.mem_read;
        mem.mem_write  <= ex.mem_write;
    end

    // decode must drop the wrong-path instruction behind a redirect.
    a_redirect_flush: assert property (
        @(posedge cpuclk) disable iff (!rst_n) redirect |=> !ex.valid
    ) else $error("instruction after redirect not flushed");

endmodule

`default_nettype wire

//--- mem_io_stage.sv
`default_nettype none
`include "cpu_params.svh"

module mem_io_stage (
    input  logic                  cpuclk,
    input  logic                  rst_n,
    mem_bus_if.consumer           mem,
    input  logic [`LED_WIDTH-1:0] switches,
    output logic [`LED_WIDTH-1:0] leds,
    output logic                  wb_we,
    output cpu_pkg::reg_idx_t     wb_rd,
    output cpu_pkg::data_t        wb_data,
    output logic                  retire_valid,
    output cpu_pkg::data_t        retire_pc,
    output cpu_pkg::reg_idx_t     retire_rd,
    output cpu_pkg::data_t        retire_data
);
    import cpu_pkg::*;

    localparam int aw = $clog2(`DMEM_DEPTH);

    data_t dmem [`DMEM_DEPTH];
    data_t load_data;
    logic  is_switch, is_led, store_en;

    assign is_switch = (mem.alu_result == `MMIO_SWITCH_ADDR);
    assign is_led    = (mem.alu_result == `MMIO_LED_ADDR);
    assign store_en  = mem.valid && mem.mem_write;

    assign load_data = is_switch ? {{(32-`LED_WIDTH){1'b0}}, switches}
                                 : dmem[mem.alu_result[aw+1:2]];

    always_ff @(posedge cpuclk) begin
        if (store_en && !is_led) begin
            dmem[mem.alu_result[aw+1:2]] <= mem.store_data;
        end
    end

    always_ff @(posedge cpuclk) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (store_en && is_led) begin
            leds <= mem.store_data[`LED_WIDTH-1:0]; // low byte only.
        end
    end

    assign wb_we   = mem.valid && mem.reg_write;
    assign wb_rd   = mem.rd;
    assign wb_data = mem.mem_read ? load_data : mem.alu_result;

    // trace mirrors the register write.
    assign retire_valid = mem.valid;
    assign retire_pc    = mem.pc;
    assign retire_rd    = wb_we ? mem.rd : '0;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

//--- cpu_top.sv
`default_nettype none
`include "cpu_params.svh"

module cpu_top (
    input  logic                  cpuclk,
    input  logic                  rst_n,
    input  cpu_pkg::data_t        uart_data,
    input  cpu_pkg::data_t        uart_addr,
    input  logic                  uart_done,
    input  logic [`LED_WIDTH-1:0] switches,
    output logic [`LED_WIDTH-1:0] leds,
    output logic                  retire_valid,
    output cpu_pkg::data_t        retire_pc,
    output cpu_pkg::reg_idx_t     retire_rd,
    output cpu_pkg::data_t        retire_data
);
    import cpu_pkg::*;

    logic     core_rst_n, redirect, id_valid, wb_we;
    data_t    fetch_pc, fetch_inst, id_pc, id_inst, redirect_pc;
    data_t    rs1_data, rs2_data, wb_data;
    reg_idx_t rs1, rs2, wb_rd;

    // core idles in reset until the program is loaded.
    assign core_rst_n = rst_n && uart_done;

    ex_bus_if  u_ex_bus ();
    mem_bus_if u_mem_bus ();

    imem_loader u_imem_loader (
        .cpuclk, .uart_done, .uart_addr, .uart_data, .fetch_pc, .fetch_inst
    );

    fetch_stage u_fetch_stage (
        .cpuclk, .rst_n(core_rst_n), .redirect, .redirect_pc, .fetch_pc, .fetch_inst,
        .id_valid, .id_pc, .id_inst
    );

    decode_stage u_decode_stage (
        .cpuclk, .rst_n(core_rst_n), .id_valid, .id_pc, .id_inst, .redirect,
        .rs1, .rs2, .rs1_data, .rs2_data, .ex(u_ex_bus.producer)
    );

    regfile u_regfile (
        .cpuclk, .rs1, .rs2, .rs1_data, .rs2_data, .wb_we, .wb_rd, .wb_data
    );

    execute_stage u_execute_stage (
        .cpuclk, .rst_n(core_rst_n), .ex(u_ex_bus.consumer), .wb_we, .wb_rd, .wb_data,
        .redirect, .redirect_pc, .mem(u_mem_bus.producer)
    );

    mem_io_stage u_mem_io_stage (
        .cpuclk, .rst_n(core_rst_n), .mem(u_mem_bus.consumer), .switches, .leds,
        .wb_we, .wb_rd, .wb_data, .retire_valid, .retire_pc, .retire_rd, .retire_data
    );

endmodule

`default_nettype wire

//--- tb_checker.sv
`default_nettype none
`include "cpu_params.svh"

module tb_checker #(
    parameter int prog_len = 1
) (
    input  logic                  cpuclk,
    input  logic                  uart_done,
    input  logic [`LED_WIDTH-1:0] switches,
    input  logic [`LED_WIDTH-1:0] leds,
    input  logic                  retire_valid,
    input  cpu_pkg::data_t        retire_pc,
    input  cpu_pkg::reg_idx_t     retire_rd,
    input  cpu_pkg::data_t        retire_data,
    output logic                  done,
    output int                    tests,
    output int                    checks,
    output int                    errors
);
    import cpu_pkg::*;

    localparam int aw = $clog2(`DMEM_DEPTH);

    data_t                 m_pc;
    data_t                 m_regs [32];
    data_t                 m_dmem [`DMEM_DEPTH];
    logic [`LED_WIDTH-1:0] m_leds;
    logic [`LED_WIDTH-1:0] led_expect;
    logic                  led_pending;
    int                    cur_test;
    int                    test_checks;
    int                    test_errors;
    int                    retired;

    initial begin
        m_pc        = `RESET_PC;
        m_leds      = '0;
        led_expect  = '0;
        led_pending = 1'b0;
        done        = 1'b0;
        tests       = 0;
        checks      = 0;
        errors      = 0;
        cur_test    = 1;
        test_checks = 0;
        test_errors = 0;
        retired     = 0;
        foreach (m_regs[i]) m_regs[i] = '0;
        foreach (m_dmem[i]) m_dmem[i] = '0;
    end

    function automatic string test_name(input int t);
        case (t)
            1:       return "loading and reset";
            2:       return "arithmetic and forwarding";
            3:       return "memory and forwarding";
            4:       return "branches and jumps";
            default: return "mmio";
        endcase
    endfunction

    // one instruction of the ISA model, state lives in the m_ variables.
    function automatic void ref_step(input data_t inst, input data_t sw_val,
                                     output reg_idx_t exp_rd, output data_t exp_data,
                                     output logic led_store, output logic is_final);
        data_t    a;
        data_t    b;
        data_t    imm_i;
        data_t    imm_s;
        data_t    imm_b;
        data_t    imm_j;
        data_t    addr;
        data_t    next_pc;
        data_t    wr;
        reg_idx_t rd;
        logic     wen;
        a         = m_regs[inst[19:15]];
        b         = m_regs[inst[24:20]];
        rd        = inst[11:7];
        imm_i     = {{20{inst[31]}}, inst[31:20]};
        imm_s     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b     = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j     = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        next_pc   = m_pc + 32'd4;
        wen       = 1'b0;
        wr        = '0;
        led_store = 1'b0;
        is_final  = 1'b0;
        case (inst[6:0])
            op_lui: begin
                wen = 1'b1;
                wr  = {inst[31:12], 12'b0};
            end
            op_imm: begin
                wen = 1'b1;
                wr  = a + imm_i;
            end
            op_reg: begin
                wen = 1'b1;
                case (inst[14:12])
                    3'b000:  wr = inst[30] ? a - b : a + b;
                    3'b010:  wr = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100:  wr = a ^ b;
                    3'b110:  wr = a | b;
                    3'b111:  wr = a & b;
                    default: wen = 1'b0;
                endcase
            end
            op_load: begin
                addr = a + imm_i;
                wen  = 1'b1;
                wr   = (addr == `MMIO_SWITCH_ADDR) ? sw_val : m_dmem[addr[aw+1:2]];
            end
            op_store: begin
                addr = a + imm_s;
                if (addr == `MMIO_LED_ADDR) begin
                    m_leds    = b[`LED_WIDTH-1:0];
                    led_store = 1'b1;
                end else begin
                    m_dmem[addr[aw+1:2]] = b;
                end
            end
            op_branch: begin
                if ((a == b) != inst[12]) next_pc = m_pc + imm_b; // bne has funct3 bit 0 set.
            end
            op_jal: begin
                wen      = 1'b1;
                wr       = m_pc + 32'd4;
                next_pc  = m_pc + imm_j;
                is_final = (imm_j == '0);
            end
            default: ;
        endcase
        if (wen && rd != '0) begin
            m_regs[rd] = wr;
        end
        exp_rd   = (wen && rd != '0) ? rd : '0;
        exp_data = wr;
        m_pc     = next_pc;
    endfunction

    task automatic check_value(input string what, input data_t got, input data_t exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        test_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic close_test();
        tests++;
        $display("test %0d (%s): %0d checks, %0d errors", cur_test, test_name(cur_test),
                 test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic retire_one();
        int       idx;
        data_t    exp_pc;
        reg_idx_t exp_rd;
        data_t    exp_data;
        logic     led_store;
        logic     is_final;
        idx = int'(m_pc >> 2);
        if (idx >= prog_len) begin
            report_failure("reference model ran past the end of the program");
            close_test();
            done = 1'b1;
        end else begin
            if (tb_cpu.test_of[idx] != cur_test) begin
                close_test();
                cur_test = tb_cpu.test_of[idx];
            end
            if (retired == 0) check_value("first retired pc", retire_pc, `RESET_PC);
            retired++;
            exp_pc = m_pc;
            ref_step(tb_cpu.prog[idx], data_t'(switches), exp_rd, exp_data, led_store, is_final);
            check_value("retired pc", retire_pc, exp_pc);
            check_value("retired rd", data_t'(retire_rd), data_t'(exp_rd));
            if (exp_rd != '0) begin
                check_value($sformatf("x%0d value", exp_rd), retire_data, exp_data);
            end
            if (led_store) begin
                led_pending = 1'b1; // leds settle one edge later.
                led_expect  = m_leds;
            end
            if (is_final) begin
                close_test();
                done = 1'b1;
            end
        end
    endtask

    always @(posedge cpuclk) begin
        if (!done) begin
            if (led_pending) begin
                check_value("leds", data_t'(leds), data_t'(led_expect));
                led_pending = 1'b0;
            end
            if (retire_valid === 1'b1 && uart_done !== 1'b1) begin
                report_failure("an instruction retired while the program was still loading");
            end else if (retire_valid === 1'b1) begin
                retire_one();
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_cpu.sv
`default_nettype none
`include "cpu_params.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int prog_len     = 38;
    localparam int reset_cycles = 3;
    localparam int dyn_insts    = 39; // executed up to the final jal.
    localparam int redirects    = 6;
    localparam int cycle_limit  = dyn_insts * 3 + redirects * 2 + prog_len + reset_cycles + 40;

    logic                  cpuclk;
    logic                  rst_n;
    logic                  uart_done;
    data_t                 uart_addr;
    data_t                 uart_data;
    logic [`LED_WIDTH-1:0] switches;
    logic [`LED_WIDTH-1:0] leds;
    logic                  retire_valid;
    data_t                 retire_pc;
    reg_idx_t              retire_rd;
    data_t                 retire_data;

    data_t  prog [prog_len];
    int     test_of [prog_len];
    int     fill_idx = 0;
    int     cycles = 0;
    integer seed;
    data_t  rnd;
    logic   done;
    int     tests;
    int     checks;
    int     errors;

    function automatic data_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic data_t i_type(int imm, int rs1, int f3, int rd, int opc);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(opc)};
    endfunction

    function automatic data_t s_type(int imm, int rs2, int rs1);
        data_t v;
        v = imm;
        return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], 7'b0100011};
    endfunction

    function automatic data_t b_type(int imm, int rs2, int rs1, int f3);
        data_t v;
        v = imm;
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic data_t u_type(int imm20, int rd);
        return {20'(imm20), 5'(rd), 7'b0110111};
    endfunction

    function automatic data_t j_type(int imm, int rd);
        data_t v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic append_inst(input data_t inst, input int test);
        prog[fill_idx]    = inst;
        test_of[fill_idx] = test;
        fill_idx++;
    endtask

    task automatic build_program();
        int sw_imm;
        int led_off;
        sw_imm  = int'(`MMIO_SWITCH_ADDR);           // sign-extends back to the top region.
        led_off = int'(`MMIO_LED_ADDR - `MMIO_SWITCH_ADDR);
        append_inst(i_type(5, 0, 0, 1, op_imm), 1);
        append_inst(u_type(32'h12345, 2), 2);
        append_inst(i_type(32'h678, 2, 0, 2, op_imm), 2);
        append_inst(r_type(0, 1, 2, 0, 3), 2);        // add x3, x2, x1.
        append_inst(r_type(32, 2, 3, 0, 4), 2);       // sub x4, x3, x2.
        append_inst(r_type(0, 2, 3, 7, 5), 2);
        append_inst(r_type(0, 4, 5, 6, 6), 2);
        append_inst(r_type(0, 3, 6, 4, 7), 2);
        append_inst(r_type(0, 7, 4, 2, 8), 2);
        append_inst(i_type(-3, 0, 0, 9, op_imm), 2);
        append_inst(r_type(0, 1, 9, 2, 10), 2);       // signed slt.
        append_inst(i_type(64, 0, 0, 11, op_imm), 3);
        append_inst(s_type(0, 7, 11), 3);
        append_inst(i_type(0, 11, 2, 12, op_load), 3);
        append_inst(r_type(0, 1, 12, 0, 13), 3);      // uses the load right away.
        append_inst(s_type(4, 13, 11), 3);
        append_inst(i_type(4, 11, 2, 14, op_load), 3);
        append_inst(r_type(32, 12, 14, 0, 15), 3);
        append_inst(b_type(8, 4, 1, 0), 4);           // beq taken.
        append_inst(i_type(99, 0, 0, 16, op_imm), 4);
        append_inst(b_type(8, 4, 1, 1), 4);           // bne not taken.
        append_inst(i_type(7, 0, 0, 17, op_imm), 4);
        append_inst(b_type(8, 0, 17, 1), 4);
        append_inst(i_type(1, 0, 0, 17, op_imm), 4);
        append_inst(b_type(8, 1, 17, 0), 4);
        append_inst(j_type(8, 18), 4);
        append_inst(i_type(1, 0, 0, 19, op_imm), 4);
        append_inst(i_type(0, 18, 0, 20, op_imm), 4); // link value.
        append_inst(i_type(3, 0, 0, 21, op_imm), 4);
        append_inst(i_type(-1, 21, 0, 21, op_imm), 4);
        append_inst(b_type(-4, 0, 21, 1), 4);         // loop back twice.
        append_inst(i_type(sw_imm, 0, 0, 22, op_imm), 5);
        append_inst(i_type(0, 22, 2, 23, op_load), 5);
        append_inst(i_type(32'h55, 23, 0, 24, op_imm), 5);
        append_inst(s_type(led_off, 24, 22), 5);
        append_inst(i_type(0, 22, 2, 25, op_load), 5);
        append_inst(s_type(led_off, 7, 22), 5);
        append_inst(j_type(0, 0), 5);                 // park here.
    endtask

    cpu_top u_cpu_top (
        .cpuclk, .rst_n, .uart_data, .uart_addr, .uart_done, .switches, .leds,
        .retire_valid, .retire_pc, .retire_rd, .retire_data
    );

    tb_checker #(.prog_len(prog_len)) u_checker (
        .cpuclk, .uart_done, .switches, .leds, .retire_valid, .retire_pc, .retire_rd,
        .retire_data, .done, .tests, .checks, .errors
    );

    initial begin
        cpuclk = 1'b0;
        forever #5 cpuclk = ~cpuclk;
    end

    initial begin
        seed     = 32'hfe5d34e3;
        switches = '0;
        forever begin
            @(negedge cpuclk);
            rnd      = $random(seed);
            switches = rnd[`LED_WIDTH-1:0];
        end
    end

    always @(posedge cpuclk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: final jal not reached within %0d cycles", cycle_limit);
            $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        rst_n     = 1'b0;
        uart_done = 1'b0;
        uart_addr = '0;
        uart_data = '0;
        build_program();
        repeat (reset_cycles) @(posedge cpuclk);
        @(negedge cpuclk);
        rst_n = 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            uart_addr = i;
            uart_data = prog[i];
            @(negedge cpuclk);
        end
        uart_done = 1'b1; // core leaves reset here.
        wait (done === 1'b1);
        @(negedge cpuclk);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
cpu_pkg.sv
pipe_if.sv
imem_loader.sv
fetch_stage.sv
decode_stage.sv
regfile.sv
execute_stage.sv
mem_io_stage.sv
cpu_top.sv
tb_checker.sv
tb_cpu.sv
